//--- Bender.yml
package:
  name: alu_self_test

export_include_dirs:
  - rtl

sources:
  - rtl/alu_test_pkg.sv
  - rtl/datapath_if.sv
  - rtl/test_step_table.sv
  - rtl/step_counter.sv
  - rtl/test_sequencer.sv
  - rtl/reg_file.sv
  - rtl/alu.sv
  - rtl/alu_self_test_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/alu_self_test_tb.sv

//--- rtl/alu.sv
`timescale 1ns/1ps
`include "alu_test_macros.svh"

module alu
    import alu_test_pkg::*;
(
    input  logic               Clk,
    input  logic               Rst,
    datapath_if.dp             dp,
    input  logic [`DATA_W-1:0] a_data,
    input  logic [`DATA_W-1:0] b_data,
    output logic [`DATA_W-1:0] result
);

    logic [`DATA_W-1:0] b_op;
    logic [`DATA_W:0]   sum;
    logic [`DATA_W:0]   diff;
    logic               add_ovf;
    alu_flags_t         flags_d;
    alu_flags_t         flags_q;

    assign b_op = dp.imm_sel ? dp.imm_val : b_data;
    assign sum  = {1'b0, a_data} + {1'b0, b_op};
    assign diff = {1'b0, a_data} - {1'b0, b_op};   // MSB is the borrow

    // Same-sign operands with a result of the other sign
    assign add_ovf = (a_data[`DATA_W-1] == b_op[`DATA_W-1]) &&
                     (sum[`DATA_W-1] != a_data[`DATA_W-1]);

    always_comb begin
        case (dp.opcode)
            OP_ADD, OP_ADDU, OP_ADDI: result = sum[`DATA_W-1:0];
            OP_CMP, OP_CMPI:          result = diff[`DATA_W-1:0];
            OP_MOVI:                  result = b_op;
            OP_LSHI:                  result = a_data << b_op;
            OP_RSHI:                  result = a_data >> b_op;
            OP_ARSHI:                 result = $signed(a_data) >>> b_op;
            default:                  result = '0;
        endcase
    end

    always_comb begin
        flags_d = flags_q;
        case (dp.opcode)
            OP_ADD, OP_ADDU, OP_ADDI: begin
                flags_d.l = 1'b0;
                flags_d.c = sum[`DATA_W];
                flags_d.f = add_ovf;
                flags_d.z = (sum[`DATA_W-1:0] == '0);
                flags_d.n = sum[`DATA_W-1];
            end
            OP_CMP, OP_CMPI: begin
                flags_d.l = diff[`DATA_W];               // Unsigned less
                flags_d.c = 1'b0;
                flags_d.f = 1'b0;
                flags_d.z = (a_data == b_op);
                flags_d.n = ($signed(a_data) < $signed(b_op));
            end
            default: flags_d = flags_q;
        endcase
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            flags_q <= '0;
        end else if (dp.exec) begin
            flags_q <= flags_d;
        end
    end

    assign dp.flags = flags_q;

endmodule

//--- rtl/alu_self_test_top.sv
`timescale 1ns/1ps
`include "alu_test_macros.svh"

module alu_self_test_top
    import alu_test_pkg::*;
(
    input  logic                   Clk,
    input  logic                   Rst,
    input  logic                   start,
    input  logic [`DATA_W-1:0]     operand_a,
    input  logic [`DATA_W-1:0]     operand_b,
    input  logic [`REG_ADDR_W-1:0] dbg_addr,
    output logic [`DATA_W-1:0]     dbg_data,
    output logic                   done,
    output logic                   pass,
    output logic [`STEP_IDX_W-1:0] fail_step,
    output logic [`DATA_W-1:0]     signature
);

    test_step_t             step;
    logic [`STEP_IDX_W-1:0] step_idx;
    logic                   last_step;
    logic                   clear;
    logic                   advance;
    logic [`DATA_W-1:0]     a_data;
    logic [`DATA_W-1:0]     b_data;
    logic [`DATA_W-1:0]     result;

    datapath_if dp_bus ();

    test_step_table u_table (
        .step_idx (step_idx),
        .step     (step)
    );

    step_counter u_counter (
        .Clk       (Clk),
        .Rst       (Rst),
        .clear     (clear),
        .advance   (advance),
        .step_idx  (step_idx),
        .last_step (last_step)
    );

    test_sequencer u_seq (
        .Clk       (Clk),
        .Rst       (Rst),
        .start     (start),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .step      (step),
        .step_idx  (step_idx),
        .last_step (last_step),
        .clear     (clear),
        .advance   (advance),
        .done      (done),
        .pass      (pass),
        .fail_step (fail_step),
        .dp        (dp_bus.seq)
    );

    reg_file u_regs (
        .Clk       (Clk),
        .Rst       (Rst),
        .dp        (dp_bus.dp),
        .result    (result),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data),
        .signature (signature),
        .a_data    (a_data),
        .b_data    (b_data)
    );

    alu u_alu (
        .Clk    (Clk),
        .Rst    (Rst),
        .dp     (dp_bus.dp),
        .a_data (a_data),
        .b_data (b_data),
        .result (result)
    );

endmodule

//--- rtl/alu_test_macros.svh
`ifndef ALU_TEST_MACROS_SVH
`define ALU_TEST_MACROS_SVH

`define DATA_W      16
`define REG_COUNT   16
`define REG_ADDR_W  4
`define FLAG_W      5

`define STEP_COUNT  19
`define STEP_IDX_W  5

// Signature written to SIG_REG at the end of a run
`define SIG_PASS    16'h2222
`define SIG_FAIL    16'hDEAD
`define SIG_REG     15

`endif

//--- rtl/alu_test_pkg.sv
`include "alu_test_macros.svh"

package alu_test_pkg;

    typedef enum logic [7:0] {
        OP_WAIT  = 8'h00,
        OP_ADD   = 8'h01,
        OP_ADDU  = 8'h02,
        OP_CMP   = 8'h0B,
        OP_ADDI  = 8'h50,
        OP_RSHI  = 8'h80,
        OP_CMPI  = 8'hB0,
        OP_LSHI  = 8'hC0,
        OP_MOVI  = 8'hD0,
        OP_ARSHI = 8'hF0
    } alu_op_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_EXEC,
        S_CHECK,
        S_PASS,
        S_FAIL,
        S_DONE
    } seq_state_e;

    typedef enum logic [1:0] {
        IMM_TABLE,
        IMM_EXT_A,
        IMM_EXT_B
    } imm_src_e;

    typedef struct packed {
        logic l;
        logic c;
        logic f;
        logic z;
        logic n;
    } alu_flags_t;

    typedef struct packed {
        alu_op_e                 opcode;
        logic [`REG_ADDR_W-1:0]  dest_addr;   // A operand
        logic [`REG_ADDR_W-1:0]  src_addr;    // B operand
        logic                    imm_sel;
        imm_src_e                imm_src;
        logic [`DATA_W-1:0]      imm_val;
        logic [`REG_ADDR_W-1:0]  wr_addr;
        logic                    wr_en;
        alu_flags_t              flag_mask;   // Zero means unchecked
        alu_flags_t              flag_expect;
    } test_step_t;

endpackage

//--- rtl/datapath_if.sv
`timescale 1ns/1ps
`include "alu_test_macros.svh"

interface datapath_if
    import alu_test_pkg::*;
();

    alu_op_e                 opcode;
    logic [`REG_ADDR_W-1:0]  a_addr;
    logic [`REG_ADDR_W-1:0]  b_addr;
    logic                    imm_sel;
    logic [`DATA_W-1:0]      imm_val;
    logic [`REG_ADDR_W-1:0]  wr_addr;
    logic                    wr_en;
    logic                    exec;      // One cycle per executed operation
    alu_flags_t              flags;

    modport seq (
        output opcode, a_addr, b_addr, imm_sel, imm_val, wr_addr, wr_en, exec,
        input  flags
    );

    modport dp (
        input  opcode, a_addr, b_addr, imm_sel, imm_val, wr_addr, wr_en, exec,
        output flags
    );

endinterface

//--- rtl/reg_file.sv
`timescale 1ns/1ps
`include "alu_test_macros.svh"

module reg_file (
    input  logic                   Clk,
    input  logic                   Rst,
    datapath_if.dp                 dp,
    input  logic [`DATA_W-1:0]     result,
    input  logic [`REG_ADDR_W-1:0] dbg_addr,
    output logic [`DATA_W-1:0]     dbg_data,
    output logic [`DATA_W-1:0]     signature,
    output logic [`DATA_W-1:0]     a_data,
    output logic [`DATA_W-1:0]     b_data
);

    logic [`DATA_W-1:0] regs [`REG_COUNT];

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (dp.exec && dp.wr_en) begin
            regs[dp.wr_addr] <= result;
        end
    end

    assign a_data    = regs[dp.a_addr];
    assign b_data    = regs[dp.b_addr];
    assign dbg_data  = regs[dbg_addr];
    assign signature = regs[`SIG_REG];     // Pass/fail word

endmodule

//--- rtl/step_counter.sv
`timescale 1ns/1ps
`include "alu_test_macros.svh"

module step_counter (
    input  logic                   Clk,
    input  logic                   Rst,
    input  logic                   clear,
    input  logic                   advance,
    output logic [`STEP_IDX_W-1:0] step_idx,
    output logic                   last_step
);

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            step_idx <= '0;
        end else if (clear) begin
            step_idx <= '0;                   // Clear wins over advance
        end else if (advance) begin
            step_idx <= step_idx + 1'b1;
        end
    end

    assign last_step = (step_idx == `STEP_IDX_W'(`STEP_COUNT - 1));

endmodule

//--- rtl/test_sequencer.sv
`timescale 1ns/1ps
`include "alu_test_macros.svh"

module test_sequencer
    import alu_test_pkg::*;
(
    input  logic                   Clk,
    input  logic                   Rst,
    input  logic                   start,
    input  logic [`DATA_W-1:0]     operand_a,
    input  logic [`DATA_W-1:0]     operand_b,
    input  test_step_t             step,
    input  logic [`STEP_IDX_W-1:0] step_idx,
    input  logic                   last_step,
    output logic                   clear,
    output logic                   advance,
    output logic                   done,
    output logic                   pass,
    output logic [`STEP_IDX_W-1:0] fail_step,
    datapath_if.seq                dp
);

    seq_state_e         state;
    seq_state_e         state_nxt;
    logic               start_ok;
    logic               mismatch;
    logic [`DATA_W-1:0] step_imm;

    assign start_ok = start && (state == S_IDLE || state == S_DONE);
    assign mismatch = |((dp.flags ^ step.flag_expect) & step.flag_mask);
    assign clear    = start_ok;
    assign advance  = (state == S_CHECK) && !mismatch && !last_step;

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE, S_DONE: if (start_ok) state_nxt = S_EXEC;
            S_EXEC:         state_nxt = S_CHECK;
            S_CHECK: begin
                if (mismatch)
                    state_nxt = S_FAIL;
                else if (last_step)
                    state_nxt = S_PASS;
                else
                    state_nxt = S_EXEC;
            end
            S_PASS, S_FAIL: state_nxt = S_DONE;
            default:        state_nxt = S_IDLE;
        endcase
    end

    always_comb begin
        case (step.imm_src)
            IMM_EXT_A: step_imm = operand_a;
            IMM_EXT_B: step_imm = operand_b;
            default:   step_imm = step.imm_val;
        endcase
    end

    always_comb begin
        dp.opcode  = step.opcode;
        dp.a_addr  = step.dest_addr;
        dp.b_addr  = step.src_addr;
        dp.imm_sel = step.imm_sel;
        dp.imm_val = step_imm;
        dp.wr_addr = step.wr_addr;
        dp.wr_en   = step.wr_en;
        if (state == S_PASS || state == S_FAIL) begin
            dp.opcode  = OP_MOVI;               // Signature goes through the normal write path
            dp.imm_sel = 1'b1;
            dp.imm_val = (state == S_PASS) ? `SIG_PASS : `SIG_FAIL;
            dp.wr_addr = `REG_ADDR_W'(`SIG_REG);
            dp.wr_en   = 1'b1;
        end
        dp.exec = (state == S_EXEC) || (state == S_PASS) || (state == S_FAIL);
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            state     <= S_IDLE;
            done      <= 1'b0;
            pass      <= 1'b0;
            fail_step <= '0;
        end else begin
            state <= state_nxt;
            if (start_ok) begin
                done      <= 1'b0;
                pass      <= 1'b0;
                fail_step <= '0;
            end else if (state == S_CHECK && mismatch) begin
                fail_step <= step_idx;
            end else if (state == S_PASS || state == S_FAIL) begin
                done <= 1'b1;
                pass <= (state == S_PASS);
            end
        end
    end

endmodule

//--- rtl/test_step_table.sv
`timescale 1ns/1ps
`include "alu_test_macros.svh"

module test_step_table
    import alu_test_pkg::*;
(
    input  logic [`STEP_IDX_W-1:0] step_idx,
    output test_step_t             step
);

    localparam alu_flags_t NONE  = 5'b00000;
    localparam alu_flags_t ZF    = 5'b00010;
    localparam alu_flags_t M_CZN = 5'b01011;
    localparam alu_flags_t E_CZN = 5'b01010;  // c=1 z=1 n=0
    localparam alu_flags_t M_FZN = 5'b00111;
    localparam alu_flags_t E_FZN = 5'b00101;  // f=1 z=0 n=1
    localparam alu_flags_t M_LZN = 5'b10011;
    localparam alu_flags_t E_LZN = 5'b00001;  // Signed less only

    function automatic test_step_t st(alu_op_e op, logic [`REG_ADDR_W-1:0] a,
                                      logic [`REG_ADDR_W-1:0] b, imm_src_e src,
                                      logic [`DATA_W-1:0] imm, logic [`REG_ADDR_W-1:0] wr,
                                      logic we, alu_flags_t msk, alu_flags_t exp_flags);
        test_step_t s;
        s.opcode      = op;
        s.dest_addr   = a;
        s.src_addr    = b;
        s.imm_sel     = op inside {OP_ADDI, OP_MOVI, OP_CMPI, OP_LSHI, OP_RSHI, OP_ARSHI};
        s.imm_src     = src;
        s.imm_val     = imm;
        s.wr_addr     = wr;
        s.wr_en       = we;
        s.flag_mask   = msk;
        s.flag_expect = exp_flags;
        return s;
    endfunction

    always_comb begin
        case (step_idx)
            5'd0:  step = st(OP_MOVI,  4'd0,  4'd0, IMM_EXT_A, 16'h0000, 4'd0,  1'b1, NONE, NONE);
            5'd1:  step = st(OP_MOVI,  4'd0,  4'd0, IMM_EXT_B, 16'h0000, 4'd1,  1'b1, NONE, NONE);
            5'd2:  step = st(OP_ADDI,  4'd0,  4'd0, IMM_TABLE, 16'h0003, 4'd2,  1'b1, NONE, NONE);
            5'd3:  step = st(OP_CMPI,  4'd2,  4'd0, IMM_TABLE, 16'h0004, 4'd0,  1'b0, ZF, ZF);
            5'd4:  step = st(OP_ADD,   4'd0,  4'd1, IMM_TABLE, 16'h0000, 4'd3,  1'b1, NONE, NONE);
            5'd5:  step = st(OP_CMPI,  4'd3,  4'd0, IMM_TABLE, 16'h0003, 4'd0,  1'b0, ZF, ZF);
            5'd6:  step = st(OP_MOVI,  4'd0,  4'd0, IMM_TABLE, 16'hFFFF, 4'd6,  1'b1, NONE, NONE);
            5'd7:  step = st(OP_ADDU,  4'd6,  4'd0, IMM_TABLE, 16'h0000, 4'd4,  1'b1, M_CZN, E_CZN);
            5'd8:  step = st(OP_LSHI,  4'd1,  4'd0, IMM_TABLE, 16'h0003, 4'd5,  1'b1, NONE, NONE);
            5'd9:  step = st(OP_CMPI,  4'd5,  4'd0, IMM_TABLE, 16'h0010, 4'd0,  1'b0, ZF, ZF);
            5'd10: step = st(OP_MOVI,  4'd0,  4'd0, IMM_TABLE, 16'h8000, 4'd14, 1'b1, NONE, NONE);
            5'd11: step = st(OP_RSHI,  4'd14, 4'd0, IMM_TABLE, 16'h0001, 4'd7,  1'b1, NONE, NONE);
            5'd12: step = st(OP_CMPI,  4'd7,  4'd0, IMM_TABLE, 16'h4000, 4'd0,  1'b0, ZF, ZF);
            5'd13: step = st(OP_ARSHI, 4'd14, 4'd0, IMM_TABLE, 16'h0001, 4'd8,  1'b1, NONE, NONE);
            5'd14: step = st(OP_CMPI,  4'd8,  4'd0, IMM_TABLE, 16'hC000, 4'd0,  1'b0, ZF, ZF);
            5'd15: step = st(OP_MOVI,  4'd0,  4'd0, IMM_TABLE, 16'h7FFF, 4'd9,  1'b1, NONE, NONE);
            5'd16: step = st(OP_ADD,   4'd9,  4'd0, IMM_TABLE, 16'h0000, 4'd10, 1'b1, M_FZN, E_FZN);
            5'd17: step = st(OP_MOVI,  4'd0,  4'd0, IMM_TABLE, 16'hFFFF, 4'd11, 1'b1, NONE, NONE);
            5'd18: step = st(OP_CMP,   4'd11, 4'd0, IMM_TABLE, 16'h0000, 4'd0,  1'b0, M_LZN, E_LZN);
            default: step = st(OP_WAIT, 4'd0, 4'd0, IMM_TABLE, 16'h0000, 4'd0, 1'b0, NONE, NONE);
        endcase
    end

endmodule

//--- sim.f
+incdir+rtl
rtl/alu_test_pkg.sv
rtl/datapath_if.sv
rtl/test_step_table.sv
rtl/step_counter.sv
rtl/test_sequencer.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/alu_self_test_top.sv
tests/tb_clock_gen.sv
tests/alu_self_test_tb.sv

//--- tests/alu_self_test_tb.sv
`timescale 1ns/1ps
`include "alu_test_macros.svh"

module alu_self_test_tb;

    localparam int RUN_CYCLES     = 45;
    localparam int RESET_CYCLES   = 4;
    localparam int READ_CYCLES    = 16 + 9;   // Debug port reads
    localparam int TIMEOUT_CYCLES = 6 * RUN_CYCLES + RESET_CYCLES + READ_CYCLES + 20;

    logic                   Clk;
    logic                   Rst;
    logic                   start;
    logic [`DATA_W-1:0]     operand_a;
    logic [`DATA_W-1:0]     operand_b;
    logic [`REG_ADDR_W-1:0] dbg_addr;
    logic [`DATA_W-1:0]     dbg_data;
    logic                   done;
    logic                   pass;
    logic [`STEP_IDX_W-1:0] fail_step;
    logic [`DATA_W-1:0]     signature;

    logic [`DATA_W-1:0]     exp_regs [`REG_COUNT];
    int                     check_count = 0;
    int                     error_count = 0;
    int                     cycle_count = 0;

    tb_clock_gen u_clk (
        .Clk (Clk),
        .Rst (Rst)
    );

    alu_self_test_top uut (
        .Clk       (Clk),
        .Rst       (Rst),
        .start     (start),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data),
        .done      (done),
        .pass      (pass),
        .fail_step (fail_step),
        .signature (signature)
    );

    always @(posedge Clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: simulation ran past %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic compare_data(input string name, input logic [`DATA_W-1:0] expected,
                                input logic [`DATA_W-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error: %s expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic compare_step(input string name, input logic [`STEP_IDX_W-1:0] expected,
                                input logic [`STEP_IDX_W-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error: %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic compare_cycles(input string name, input int expected, input int actual);
        check_count++;
        if (actual != expected) begin
            error_count++;
            $display("Error: %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    // Reference model of the step program; fail_idx is -1 on pass
    task automatic model_program(input logic [`DATA_W-1:0] a, input logic [`DATA_W-1:0] b,
                                 output int fail_idx);
        logic [`DATA_W:0] wide;
        logic             ovf;
        for (int i = 0; i < `REG_COUNT; i++) begin
            exp_regs[i] = '0;
        end
        fail_idx = -1;
        exp_regs[0] = a;
        exp_regs[1] = b;
        exp_regs[2] = exp_regs[0] + 16'd3;
        if (exp_regs[2] != 16'd4) begin
            fail_idx = 3;
            return;
        end
        exp_regs[3] = exp_regs[0] + exp_regs[1];
        if (exp_regs[3] != 16'd3) begin
            fail_idx = 5;
            return;
        end
        exp_regs[6] = 16'hFFFF;
        wide = {1'b0, exp_regs[6]} + {1'b0, exp_regs[0]};
        exp_regs[4] = wide[`DATA_W-1:0];
        if (!wide[`DATA_W] || exp_regs[4] != '0 || exp_regs[4][`DATA_W-1]) begin
            fail_idx = 7;                      // Expect c=1 z=1 n=0
            return;
        end
        exp_regs[5] = exp_regs[1] << 3;
        if (exp_regs[5] != 16'h0010) begin
            fail_idx = 9;
            return;
        end
        exp_regs[14] = 16'h8000;
        exp_regs[7] = exp_regs[14] >> 1;
        if (exp_regs[7] != 16'h4000) begin
            fail_idx = 12;
            return;
        end
        exp_regs[8] = $signed(exp_regs[14]) >>> 1;
        if (exp_regs[8] != 16'hC000) begin
            fail_idx = 14;
            return;
        end
        exp_regs[9] = 16'h7FFF;
        exp_regs[10] = exp_regs[9] + exp_regs[0];
        ovf = (exp_regs[9][15] == exp_regs[0][15]) && (exp_regs[10][15] != exp_regs[9][15]);
        if (!ovf || !exp_regs[10][15] || exp_regs[10] == '0) begin
            fail_idx = 16;
            return;
        end
        exp_regs[11] = 16'hFFFF;
        if (!($signed(exp_regs[11]) < $signed(exp_regs[0])) ||
            (exp_regs[11] < exp_regs[0]) || (exp_regs[11] == exp_regs[0])) begin
            fail_idx = 18;
            return;
        end
    endtask

    task automatic read_reg(input logic [`REG_ADDR_W-1:0] addr, output logic [`DATA_W-1:0] data);
        @(posedge Clk);
        dbg_addr <= addr;
        @(negedge Clk);
        data = dbg_data;
    endtask

    // Cycles count from the edge that drives start to the edge that raises done
    task automatic run_program(input logic [`DATA_W-1:0] a, input logic [`DATA_W-1:0] b,
                               input int glitch_at, output int cycles);
        @(posedge Clk);
        operand_a <= a;
        operand_b <= b;
        start     <= 1'b1;
        @(posedge Clk);
        start  <= 1'b0;
        cycles = 1;
        @(negedge Clk);
        while (!done && cycles < RUN_CYCLES) begin
            @(posedge Clk);
            cycles++;
            start <= (cycles == glitch_at);    // Pulse inside the run
            @(negedge Clk);
        end
        if (!done) begin
            error_count++;
            $display("Run with operands %h and %h never raised done", a, b);
        end
    endtask

    task automatic check_run(input string name, input logic [`DATA_W-1:0] a,
                             input logic [`DATA_W-1:0] b, input int glitch_at);
        int fail_idx;
        int cycles;
        int last_idx;
        model_program(a, b, fail_idx);
        run_program(a, b, glitch_at, cycles);
        last_idx = (fail_idx < 0) ? `STEP_COUNT - 1 : fail_idx;
        compare_cycles({name, " done latency"}, 4 + 2 * last_idx, cycles);
        compare_bit({name, " pass"}, fail_idx < 0, pass);
        compare_step({name, " fail_step"}, (fail_idx < 0) ? 0 : fail_idx, fail_step);
        compare_data({name, " signature"}, (fail_idx < 0) ? `SIG_PASS : `SIG_FAIL, signature);
    endtask

    task automatic verify_reset_state();
        logic [`DATA_W-1:0] data;
        compare_bit("reset done", 1'b0, done);
        compare_bit("reset pass", 1'b0, pass);
        compare_step("reset fail_step", '0, fail_step);
        compare_data("reset signature", '0, signature);
        for (int i = 0; i < `REG_COUNT; i++) begin
            read_reg(i, data);
            compare_data($sformatf("reset R%0d", i), '0, data);
        end
    endtask

    task automatic run_nominal();
        check_run("nominal", 16'd1, 16'd2, 0);
    endtask

    task automatic read_result_registers();
        int                 idx_list [9] = '{2, 3, 4, 5, 7, 8, 10, 11, 14};
        int                 fail_idx;
        logic [`DATA_W-1:0] data;
        model_program(16'd1, 16'd2, fail_idx);
        foreach (idx_list[i]) begin
            read_reg(idx_list[i], data);
            compare_data($sformatf("result R%0d", idx_list[i]), exp_regs[idx_list[i]], data);
        end
    endtask

    task automatic inject_faults();
        check_run("fault operand_a", 16'd2, 16'd2, 0);   // Fails at step 3
        check_run("fault operand_b", 16'd1, 16'd3, 0);   // Fails at step 5
    endtask

    task automatic restart_runs();
        check_run("start ignored", 16'd1, 16'd2, 15);
        check_run("failed run", 16'd2, 16'd2, 0);
        check_run("rerun after fail", 16'd1, 16'd2, 0);
    endtask

    initial begin
        start     = 1'b0;
        operand_a = 16'd1;
        operand_b = 16'd2;
        dbg_addr  = '0;
        @(negedge Rst);
        @(negedge Clk);
        verify_reset_state();
        run_nominal();
        read_result_registers();
        inject_faults();
        restart_runs();
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic Clk,
    output logic Rst
);

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;                // 100 ns period
    end

    initial begin
        Rst = 1'b1;
        repeat (4) @(posedge Clk);
        Rst <= 1'b0;
    end

endmodule
